/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_minisys_ctc
RTL_TOP    ?= minisys_ctc
FILELIST   ?= tb.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= test failed
PASS_MSG   ?= test passed
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= -Wall
RTL_SRCS   ?= logic/minisys_ctc_pkg.sv logic/ctc_decode.sv logic/ctc_channel.sv \
              logic/ctc_readback.sv logic/minisys_ctc.sv
TB_SRCS    ?= bench/minisys_ctc_props.sv bench/tb_minisys_ctc.sv
SIM        := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(RTL_SRCS) $(TB_SRCS) logic/minisys_ctc_consts.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "failure reported, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended early, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) +incdir+logic --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/minisys_ctc_props.sv */
`timescale 1ns/1ps
`include "minisys_ctc_consts.svh"

module minisys_ctc_props import minisys_ctc_pkg::*; #(
    parameter int NUM_CTC = `CTC_NUM
) (
    input  logic                  clock,
    input  logic                  rst_n,
    input  io_req_t               req,
    input  logic                  rd_valid,
    input  logic    [NUM_CTC-1:0] ctc_out,
    input  logic                  irq,
    input  ctc_rd_t [NUM_CTC-1:0] rd_bus    // internal channel outputs
);

    logic any_done;    // done of any channel this cycle

    always_comb begin
        any_done = 1'b0;
        for (int i = 0; i < NUM_CTC; i++) begin
            any_done = any_done | rd_bus[i].done;
        end
    end

    // read data always returns in the next cycle
    a_rd_valid_after_read: assert property (@(posedge clock) disable iff (!rst_n)
        req.ioread |=> rd_valid)
        else $error("rd_valid missing one cycle after ioread");

    a_rd_valid_only_after_read: assert property (@(posedge clock) disable iff (!rst_n)
        !req.ioread |=> !rd_valid)
        else $error("rd_valid high without a read in the cycle before");

    // terminal count pulses never stretch
    a_out_single_cycle: assert property (@(posedge clock) disable iff (!rst_n)
        (ctc_out & $past(ctc_out)) == '0)
        else $error("ctc_out high for more than one cycle");

    a_irq_needs_done: assert property (@(posedge clock) disable iff (!rst_n)
        !any_done |=> !irq)
        else $error("irq high with no done flag in the cycle before");

endmodule

bind minisys_ctc minisys_ctc_props #(
    .NUM_CTC  (NUM_CTC)
) i_props (
    .clock    (clock),
    .rst_n    (rst_n),
    .req      (req),
    .rd_valid (rd_valid),
    .ctc_out  (ctc_out),
    .irq      (irq),
    .rd_bus   (rd_bus)
);

/* bench/tb_minisys_ctc.sv */
`timescale 1ns/1ps
`include "minisys_ctc_consts.svh"

module tb_minisys_ctc import minisys_ctc_pkg::*; ();

    localparam int NUM_CTC = `CTC_NUM;

    typedef enum int {
        OP_WRITE,       // register write, no bus error
        OP_READ,        // compare data, bus error past the last channel
        OP_BAD_WRITE,   // write into the hole at channel offset 4
        OP_WAIT,        // idle cycles
        OP_PULSE,       // event high then low, cycles each
        OP_WAIT_OUT,    // edges until ctc_out goes high
        OP_FLAGS        // exp bit 0 irq, bit 1 ctc_out
    } op_e;

    typedef struct {
        int          test;
        op_e         op;
        int          ch;
        ctc_reg_e    rsel;
        logic [15:0] data;
        logic [15:0] exp;
        int          cycles;
    } row_t;

    logic               clock;
    logic               rst_n;
    io_req_t            req;
    logic [NUM_CTC-1:0] ctc_event;
    logic [15:0]        ioread_data;
    logic               rd_valid;
    logic [NUM_CTC-1:0] ctc_out;
    logic               irq;
    logic               bus_error;

    row_t rows[$];
    int   limit_cycles = 0;   // set once the table is built
    int   n_checks = 0;
    int   n_errors = 0;
    int   t_checks = 0;       // per test
    int   t_errors = 0;

    minisys_ctc i_minisys_ctc (
        .clock       (clock),
        .rst_n       (rst_n),
        .req         (req),
        .ctc_event   (ctc_event),
        .ioread_data (ioread_data),
        .rd_valid    (rd_valid),
        .ctc_out     (ctc_out),
        .irq         (irq),
        .bus_error   (bus_error)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;   // 100 ns period
    end

    // budget from the table, 50 cycles of slack per row
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clock);
        $display("timeout: stimulus table not finished after %0d clock cycles", limit_cycles);
        $display("test failed");
        $finish;
    end

    function automatic void add_row(input int test, input op_e op, input int ch,
                                    input ctc_reg_e rsel, input int data, input int exp,
                                    input int cycles);
        row_t r;
        r.test   = test;
        r.op     = op;
        r.ch     = ch;
        r.rsel   = rsel;
        r.data   = 16'(data);
        r.exp    = 16'(exp);
        r.cycles = cycles;
        rows.push_back(r);
    endfunction

    // status word: bit 2 mode, bit 1 running, bit 0 done
    function automatic void build_table();
        add_row(1, OP_READ, 0, REG_COUNT, 0, 0, 0);
        add_row(1, OP_READ, 0, REG_CTRL, 0, 0, 0);
        add_row(1, OP_READ, 1, REG_COUNT, 0, 0, 0);
        add_row(1, OP_READ, 1, REG_CTRL, 0, 0, 0);
        add_row(1, OP_FLAGS, 0, REG_CTRL, 0, 0, 0);
        add_row(1, OP_FLAGS, 1, REG_CTRL, 0, 0, 0);
        add_row(2, OP_WRITE, 0, REG_CTRL, 0, 0, 0);       // timer, one-shot
        add_row(2, OP_WRITE, 0, REG_COUNT, 7, 0, 0);
        add_row(2, OP_WAIT_OUT, 0, REG_CTRL, 0, 0, 7);
        add_row(2, OP_WAIT, 0, REG_CTRL, 0, 0, 1);        // irq one cycle behind done
        add_row(2, OP_FLAGS, 0, REG_CTRL, 0, 1, 0);
        add_row(2, OP_READ, 0, REG_CTRL, 0, 1, 0);        // done, timer
        add_row(2, OP_READ, 0, REG_CTRL, 0, 0, 0);        // done cleared by the read
        add_row(2, OP_READ, 0, REG_COUNT, 0, 0, 0);
        add_row(2, OP_FLAGS, 0, REG_CTRL, 0, 0, 0);
        add_row(3, OP_WRITE, 0, REG_CTRL, 2, 0, 0);       // timer, repeat
        add_row(3, OP_WRITE, 0, REG_COUNT, 5, 0, 0);
        add_row(3, OP_WAIT_OUT, 0, REG_CTRL, 0, 0, 5);
        add_row(3, OP_WAIT_OUT, 0, REG_CTRL, 0, 0, 5);
        add_row(3, OP_WAIT_OUT, 0, REG_CTRL, 0, 0, 5);
        add_row(3, OP_READ, 0, REG_COUNT, 0, 5, 0);       // k = 0
        add_row(3, OP_READ, 0, REG_COUNT, 0, 4, 0);       // k = 1
        add_row(3, OP_WAIT, 0, REG_CTRL, 0, 0, 1);
        add_row(3, OP_READ, 0, REG_COUNT, 0, 2, 0);       // k = 3
        add_row(3, OP_WAIT_OUT, 0, REG_CTRL, 0, 0, 1);    // 5 - 4 left
        add_row(3, OP_WRITE, 0, REG_CTRL, 0, 0, 0);       // stop
        add_row(3, OP_READ, 0, REG_CTRL, 0, 0, 0);
        add_row(4, OP_WRITE, 1, REG_CTRL, 1, 0, 0);       // counter, one-shot
        add_row(4, OP_WRITE, 1, REG_COUNT, 4, 0, 0);
        add_row(4, OP_PULSE, 1, REG_CTRL, 0, 0, 3);
        add_row(4, OP_PULSE, 1, REG_CTRL, 0, 0, 3);
        add_row(4, OP_PULSE, 1, REG_CTRL, 0, 0, 3);
        add_row(4, OP_READ, 1, REG_COUNT, 0, 1, 0);
        add_row(4, OP_PULSE, 1, REG_CTRL, 0, 0, 3);
        add_row(4, OP_READ, 1, REG_CTRL, 0, 5, 0);        // done, counter
        add_row(4, OP_READ, 1, REG_CTRL, 0, 4, 0);
        add_row(4, OP_READ, 1, REG_COUNT, 0, 0, 0);
        add_row(5, OP_WRITE, 0, REG_CTRL, 0, 0, 0);
        add_row(5, OP_WRITE, 0, REG_COUNT, 10, 0, 0);     // edge t
        add_row(5, OP_WRITE, 1, REG_CTRL, 1, 0, 0);
        add_row(5, OP_WRITE, 1, REG_COUNT, 3, 0, 0);
        add_row(5, OP_READ, 0, REG_COUNT, 0, 8, 0);       // two edges after t
        add_row(5, OP_PULSE, 1, REG_CTRL, 0, 0, 2);
        add_row(5, OP_READ, 1, REG_COUNT, 0, 2, 0);
        add_row(5, OP_WAIT_OUT, 0, REG_CTRL, 0, 0, 2);    // ch0 pulse at t + 10
        add_row(5, OP_READ, 1, REG_COUNT, 0, 2, 0);
        add_row(5, OP_READ, 0, REG_CTRL, 0, 1, 0);
        add_row(5, OP_READ, 1, REG_CTRL, 0, 6, 0);        // running, counter
        add_row(6, OP_BAD_WRITE, 0, REG_CTRL, 3, 0, 0);   // base + 4
        add_row(6, OP_READ, 2, REG_CTRL, 0, 0, 0);        // first address past ch1
        add_row(6, OP_READ, 1, REG_CTRL, 0, 6, 0);
        add_row(6, OP_READ, 1, REG_COUNT, 0, 2, 0);
        add_row(6, OP_READ, 0, REG_CTRL, 0, 0, 0);
        add_row(6, OP_FLAGS, 0, REG_CTRL, 0, 0, 0);
    endfunction

    function automatic string test_title(input int t);
        case (t)
            1:       return "reset state";
            2:       return "timer one-shot";
            3:       return "timer repeat";
            4:       return "event counter";
            5:       return "channel independence";
            6:       return "bus errors";
            default: return "unnamed";
        endcase
    endfunction

    task automatic check_data(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
        t_checks++;
        if (got !== exp) begin
            t_errors++;
            $display("CHECK FAILED time %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        t_checks++;
        if (got !== exp) begin
            t_errors++;
            $display("CHECK FAILED time %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic report_error(input string what);
        t_checks++;
        t_errors++;
        $display("ERROR time %0t: %s", $time, what);
    endtask

    task automatic end_test(input int t);
        $display("test %0d (%s): %0d checks, %0d errors", t, test_title(t), t_checks, t_errors);
        n_checks += t_checks;
        n_errors += t_errors;
        t_checks = 0;
        t_errors = 0;
    endtask

    function automatic logic [15:0] ch_addr(input row_t r);
        logic [15:0] a;
        a = `CTC_IO_BASE + 16'(r.ch * `CTC_STRIDE);
        if (r.op == OP_BAD_WRITE) begin
            a = a + 16'd4;   // no register there
        end else if (r.rsel == REG_COUNT) begin
            a = a + 16'd2;
        end
        return a;
    endfunction

    function automatic logic ctc_out_bit(input int ch);
        logic b;
        b = 1'b0;
        for (int i = 0; i < NUM_CTC; i++) begin
            if (i == ch) b = ctc_out[i];
        end
        return b;
    endfunction

    task automatic set_event(input int ch, input logic val);
        for (int i = 0; i < NUM_CTC; i++) begin
            if (i == ch) ctc_event[i] = val;
        end
    endtask

    // every step ends 5 ns after a rising edge
    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clock);
            #5;
        end
    endtask

    task automatic bus_cycle(input logic [15:0] addr, input logic [15:0] wdata,
                             input logic rd, input logic wr);
        req.addr    = addr;
        req.wdata   = wdata;
        req.ioread  = rd;
        req.iowrite = wr;
        idle(1);   // strobe taken at this edge
        req = '0;
    endtask

    task automatic run_row(input row_t r);
        int n;
        case (r.op)
            OP_WRITE, OP_BAD_WRITE: begin
                bus_cycle(ch_addr(r), r.data, 1'b0, 1'b1);
                check_bit("bus_error", bus_error, r.op == OP_BAD_WRITE);
            end
            OP_READ: begin
                bus_cycle(ch_addr(r), 16'd0, 1'b1, 1'b0);
                check_bit("bus_error", bus_error, r.ch >= NUM_CTC);
                n = 1;
                while (!rd_valid && n < 4) begin
                    idle(1);
                    n++;
                end
                if (!rd_valid) begin
                    report_error("no rd_valid within 4 cycles of a read");
                end else begin
                    check_data("read latency", 16'(n), 16'd1);
                    check_data("ioread_data", ioread_data, r.exp);
                end
            end
            OP_WAIT: idle(r.cycles);
            OP_PULSE: begin
                set_event(r.ch, 1'b1);
                idle(r.cycles);
                set_event(r.ch, 1'b0);
                idle(r.cycles);
            end
            OP_WAIT_OUT: begin
                n = 0;
                do begin
                    idle(1);
                    n++;
                end while (!ctc_out_bit(r.ch) && n < r.cycles + 20);
                if (!ctc_out_bit(r.ch)) begin
                    report_error($sformatf("ctc_out[%0d] never pulsed", r.ch));
                end else begin
                    check_data($sformatf("ctc_out[%0d] delay", r.ch), 16'(n), 16'(r.cycles));
                end
            end
            OP_FLAGS: begin
                check_bit("irq", irq, r.exp[0]);
                check_bit($sformatf("ctc_out[%0d]", r.ch), ctc_out_bit(r.ch), r.exp[1]);
                check_bit("bus_error", bus_error, 1'b0);
            end
            default: report_error("unknown operation in the stimulus table");
        endcase
    endtask

    initial begin
        int cur;
        int sum;
        rst_n     = 1'b0;
        req       = '0;
        ctc_event = '0;
        build_table();
        sum = 16;   // reset cycles
        foreach (rows[i]) begin
            sum += rows[i].cycles + 50;
        end
        limit_cycles = sum;
        idle(16);
        rst_n = 1'b1;
        cur = rows[0].test;
        foreach (rows[i]) begin
            if (rows[i].test != cur) begin
                end_test(cur);
                cur = rows[i].test;
            end
            run_row(rows[i]);
        end
        end_test(cur);
        $display("total: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* logic/ctc_channel.sv */
`timescale 1ns/1ps
`include "minisys_ctc_consts.svh"

module ctc_channel import minisys_ctc_pkg::*; (
    input  logic        clock,
    input  logic        rst_n,
    input  logic        sel,       // decoder hit for this channel
    input  ctc_reg_e    reg_sel,
    input  logic [15:0] wdata,
    input  logic        ioread,
    input  logic        iowrite,
    input  logic        event_in,  // async pin, counter mode source
    output ctc_rd_t     rd,
    output logic        ctc_out    // one-cycle pulse at terminal count
);

    localparam int         W   = `CTC_WIDTH;
    localparam logic [W-1:0] ONE = W'(1);

    ctc_mode_e  mode;
    ctc_state_e state;
    logic       rpt;               // reload and keep running
    logic       done;
    logic [W-1:0] reload;
    logic [W-1:0] count;

    // event path, two flops then edge detect
    logic ev_meta;
    logic ev_sync;
    logic ev_prev;
    logic ev_rise;
    logic tick;                    // one decrement this cycle

    logic wr_ctrl;
    logic wr_count;
    logic rd_status;
    logic [15:0] status;

    always_comb begin
        ev_rise   = ev_sync & ~ev_prev;
        tick      = (mode == CTC_TIMER) ? 1'b1 : ev_rise;

        wr_ctrl   = sel && iowrite && (reg_sel == REG_CTRL);
        wr_count  = sel && iowrite && (reg_sel == REG_COUNT);
        rd_status = sel && ioread  && (reg_sel == REG_CTRL);

        // bit 2 mode, bit 1 running, bit 0 done
        status    = {13'd0, mode == CTC_COUNTER, state == CTC_RUN, done};

        rd.done   = done;
        rd.rdata  = (reg_sel == REG_CTRL) ? status : count;
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            ev_meta <= 1'b0;
            ev_sync <= 1'b0;
            ev_prev <= 1'b0;
            mode    <= CTC_TIMER;
            rpt     <= 1'b0;
            state   <= CTC_IDLE;
            done    <= 1'b0;
            reload  <= '0;
            count   <= '0;
            ctc_out <= 1'b0;
        end else begin
            ev_meta <= event_in;
            ev_sync <= ev_meta;
            ev_prev <= ev_sync;
            ctc_out <= 1'b0;   // default low, pulse set below

            // status read acks done, a new terminal count below still wins
            if (rd_status) begin
                done <= 1'b0;
            end

            if (wr_ctrl) begin
                mode  <= ctc_mode_e'(wdata[0]);
                rpt   <= wdata[1];
                state <= CTC_IDLE;     // reprogramming stops the channel
                done  <= 1'b0;
            end else if (wr_count) begin
                reload <= wdata[W-1:0];
                count  <= wdata[W-1:0];
                // zero reload means nothing to count
                state  <= (wdata != 16'd0) ? CTC_RUN : CTC_IDLE;
            end else if (state == CTC_RUN && tick) begin
                if (count == ONE) begin
                    ctc_out <= 1'b1;
                    done    <= 1'b1;
                    if (rpt) begin
                        count <= reload;   // period stays reload cycles
                    end else begin
                        count <= '0;
                        state <= CTC_DONE;
                    end
                end else begin
                    count <= count - ONE;
                end
            end
        end
    end

endmodule

/* logic/ctc_decode.sv */
`timescale 1ns/1ps
`include "minisys_ctc_consts.svh"

module ctc_decode import minisys_ctc_pkg::*; #(
    parameter int NUM_CTC = `CTC_NUM
) (
    input  logic               clock,
    input  logic               rst_n,
    input  io_req_t            req,
    output logic [NUM_CTC-1:0] sel,       // one-hot channel strobe qualifier
    output ctc_reg_e           reg_sel,
    output logic [NUM_CTC-1:0] rd_sel_q,  // read selects, one cycle late
    output logic               bus_error
);

    localparam int          SHIFT    = $clog2(`CTC_STRIDE);
    localparam logic [15:0] OFF_MASK = 16'(`CTC_STRIDE - 1);
    localparam logic [15:0] MAP_END  = 16'(NUM_CTC * `CTC_STRIDE);  // end of live channels
    localparam logic [15:0] WIN_END  = 16'(4 * `CTC_STRIDE);        // end of reserved window

    logic [15:0] off;        // offset from base, wraps high below base
    logic [15:0] idx;        // channel number
    logic [15:0] reg_off;    // byte offset inside the channel
    logic        access;
    logic        in_win;
    logic        mapped;
    logic        reg_hit;
    logic        err_d;

    always_comb begin
        off     = req.addr - `CTC_IO_BASE;
        idx     = off >> SHIFT;
        reg_off = off & OFF_MASK;
        access  = req.ioread | req.iowrite;

        // below base the subtraction wraps, so one compare covers both ends
        in_win  = off < WIN_END;
        mapped  = off < MAP_END;
        reg_hit = (reg_off == 16'd0) || (reg_off == 16'd2);

        reg_sel = reg_off[1] ? REG_COUNT : REG_CTRL;

        for (int i = 0; i < NUM_CTC; i++) begin
            sel[i] = access && mapped && reg_hit && (idx == 16'(i));
        end

        // in the ctc window but nothing answers
        err_d = access && in_win && !(mapped && reg_hit);
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            rd_sel_q  <= '0;
            bus_error <= 1'b0;
        end else begin
            rd_sel_q  <= sel & {NUM_CTC{req.ioread}};  // writes never select readback
            bus_error <= err_d;                          // one-cycle pulse
        end
    end

endmodule

/* logic/ctc_readback.sv */
`timescale 1ns/1ps
`include "minisys_ctc_consts.svh"

module ctc_readback import minisys_ctc_pkg::*; #(
    parameter int NUM_CTC = `CTC_NUM
) (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  ioread,
    input  logic    [NUM_CTC-1:0] rd_sel_q,    // one-hot, zero on unmapped read
    input  ctc_rd_t [NUM_CTC-1:0] rd_bus,
    output logic    [15:0]        ioread_data,
    output logic                  rd_valid,
    output logic                  irq
);

    logic [15:0] hold [NUM_CTC];   // read word snapshot per channel
    logic        any_done;

    always_comb begin
        any_done = 1'b0;
        for (int i = 0; i < NUM_CTC; i++) begin
            any_done = any_done | rd_bus[i].done;
        end
    end

    // sampled in the read cycle, before a status read clears done
    always_ff @(posedge clock) begin
        if (ioread) begin
            for (int i = 0; i < NUM_CTC; i++) begin
                hold[i] <= rd_bus[i].rdata;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
            irq      <= 1'b0;
        end else begin
            rd_valid <= ioread;    // fixed one-cycle latency
            irq      <= any_done;  // lags done by a cycle
        end
    end

    // and-or mux, no select gives 0
    always_comb begin
        ioread_data = 16'd0;
        for (int i = 0; i < NUM_CTC; i++) begin
            ioread_data = ioread_data | (hold[i] & {16{rd_sel_q[i]}});
        end
    end

endmodule

/* logic/minisys_ctc.sv */
`timescale 1ns/1ps
`include "minisys_ctc_consts.svh"

module minisys_ctc import minisys_ctc_pkg::*; #(
    parameter int NUM_CTC = `CTC_NUM
) (
    input  logic               clock,
    input  logic               rst_n,
    input  io_req_t            req,
    input  logic [NUM_CTC-1:0] ctc_event,    // async event pins
    output logic [15:0]        ioread_data,
    output logic               rd_valid,
    output logic [NUM_CTC-1:0] ctc_out,
    output logic               irq,
    output logic               bus_error
);

    logic    [NUM_CTC-1:0] sel;
    ctc_reg_e              reg_sel;      // shared by all channels
    logic    [NUM_CTC-1:0] rd_sel_q;
    ctc_rd_t [NUM_CTC-1:0] rd_bus;

    ctc_decode #(
        .NUM_CTC   (NUM_CTC)
    ) i_decode (
        .clock     (clock),
        .rst_n     (rst_n),
        .req       (req),
        .sel       (sel),
        .reg_sel   (reg_sel),
        .rd_sel_q  (rd_sel_q),
        .bus_error (bus_error)
    );

    // strobes and write data go straight to every channel, sel qualifies
    for (genvar i = 0; i < NUM_CTC; i++) begin : g_ch
        ctc_channel i_ch (
            .clock    (clock),
            .rst_n    (rst_n),
            .sel      (sel[i]),
            .reg_sel  (reg_sel),
            .wdata    (req.wdata),
            .ioread   (req.ioread),
            .iowrite  (req.iowrite),
            .event_in (ctc_event[i]),
            .rd       (rd_bus[i]),
            .ctc_out  (ctc_out[i])
        );
    end

    ctc_readback #(
        .NUM_CTC     (NUM_CTC)
    ) i_readback (
        .clock       (clock),
        .rst_n       (rst_n),
        .ioread      (req.ioread),
        .rd_sel_q    (rd_sel_q),
        .rd_bus      (rd_bus),
        .ioread_data (ioread_data),
        .rd_valid    (rd_valid),
        .irq         (irq)
    );

endmodule

/* logic/minisys_ctc_consts.svh */
`ifndef MINISYS_CTC_CONSTS_SVH
`define MINISYS_CTC_CONSTS_SVH

// first byte of the ctc window in io space
`define CTC_IO_BASE 16'hFC20

// bytes per channel, ctrl at +0 and count at +2
`define CTC_STRIDE 8

// default channel count, window always spans 4 strides
`define CTC_NUM 2

// down-counter width
`define CTC_WIDTH 16

`endif

/* logic/minisys_ctc_pkg.sv */
package minisys_ctc_pkg;

    // one cpu i/o access, strobes as the cpu drives them
    typedef struct packed {
        logic [15:0] addr;     // byte address on the io bus
        logic [15:0] wdata;    // low half of write_data
        logic        ioread;   // read strobe
        logic        iowrite;  // write strobe
    } io_req_t;

    // register inside a channel, picked by offset bit 1
    typedef enum logic {
        REG_CTRL  = 1'b0,      // w: mode, r: status
        REG_COUNT = 1'b1       // w: reload, r: live count
    } ctc_reg_e;

    // what the down-counter counts
    typedef enum logic {
        CTC_TIMER   = 1'b0,    // clock cycles
        CTC_COUNTER = 1'b1     // event pin edges
    } ctc_mode_e;

    typedef enum logic [1:0] {
        CTC_IDLE = 2'd0,
        CTC_RUN  = 2'd1,
        CTC_DONE = 2'd2        // one-shot expired, count parked at 0
    } ctc_state_e;

    // per channel toward readback
    typedef struct packed {
        logic [15:0] rdata;    // status or count, follows reg_sel
        logic        done;     // feeds the irq merge
    } ctc_rd_t;

endpackage

/* tb.f */
+incdir+logic
logic/minisys_ctc_pkg.sv
logic/ctc_decode.sv
logic/ctc_channel.sv
logic/ctc_readback.sv
logic/minisys_ctc.sv
bench/minisys_ctc_props.sv
bench/tb_minisys_ctc.sv
